// ==== design/awg_pkg.sv ====
/*
 shared types and constants for the waveform player
 SPI frame struct, memory word union, commands and register map
*/
package awg_pkg;

	// ------------------------------
	// spi transaction
	// ------------------------------

	// one received frame, command first on the wire
	typedef struct packed {
		logic [7:0]  command8;
		logic [15:0] address16;
		logic [31:0] data32;
	} spi_frame_t;

	localparam logic [7:0] CMD_WRITE = 8'h01; // anything else is a read

	// ------------------------------
	// waveform memory word
	// ------------------------------

	// word32 is the spi view, bytes the playback view
	// bytes[0] plays first and is the msb sent on spi,
	// so the stored word is byte swapped relative to spi
	typedef union packed {
		logic [31:0]     word32;
		logic [3:0][7:0] bytes;
	} sample_word_u;

	// ------------------------------
	// control register map
	// ------------------------------

	localparam logic [3:0] REG_START = 4'd0; // playback window start
	localparam logic [3:0] REG_END = 4'd1;   // playback window end, exclusive

	// playback byte address width
	// register bits 15:2 hold the byte address
	localparam int SAMPLE_AW = 14;

endpackage

// ==== design/awg_top.sv ====
`timescale 1ns/10ps
/*
 waveform player top level: two SPI slaves on one bus, control registers,
 waveform memory and playback sequencer
*/
module awg_top import awg_pkg::*; #(
	parameter int MEM_AW = 12,
	parameter int REG_AW = 4
) (
	input  logic       word_clock,
	input  logic       reset4_word_clock,
	input  logic       spi_sclk,
	input  logic       spi_mosi,
	input  logic       spi_ce0_n,
	input  logic       spi_ce1_n,
	output logic       spi_miso,
	output logic [7:0] sample_out,
	output logic       sync_out,
	output logic       ready
);
	spi_frame_t frame_ce0;
	spi_frame_t frame_ce1;
	logic transaction_valid_ce0;
	logic transaction_valid_ce1;
	logic [31:0] read_word_ce0;
	logic [31:0] read_word_ce1;
	logic miso_ce0;
	logic miso_ce1;
	logic [31:0] start_reg;
	logic [31:0] end_reg;
	logic [MEM_AW+1:0] sample_address;

	// ------------------------------
	// chip select 0, control registers
	// ------------------------------
	spi_slave_cmd_addr_data u_spi_ce0 (
		.word_clock        (word_clock),
		.reset4_word_clock (reset4_word_clock),
		.sclk              (spi_sclk),
		.mosi              (spi_mosi),
		.ssel_n            (spi_ce0_n),
		.miso              (miso_ce0),
		.frame             (frame_ce0),
		.transaction_valid (transaction_valid_ce0),
		.read_word         (read_word_ce0)
	);

	control_registers #(.REG_AW(REG_AW)) u_control_registers (
		.word_clock        (word_clock),
		.reset4_word_clock (reset4_word_clock),
		.frame             (frame_ce0),
		.transaction_valid (transaction_valid_ce0),
		.read_word         (read_word_ce0),
		.start_reg         (start_reg),
		.end_reg           (end_reg)
	);

	// ------------------------------
	// chip select 1, waveform memory
	// ------------------------------
	spi_slave_cmd_addr_data u_spi_ce1 (
		.word_clock        (word_clock),
		.reset4_word_clock (reset4_word_clock),
		.sclk              (spi_sclk),
		.mosi              (spi_mosi),
		.ssel_n            (spi_ce1_n),
		.miso              (miso_ce1),
		.frame             (frame_ce1),
		.transaction_valid (transaction_valid_ce1),
		.read_word         (read_word_ce1)
	);

	waveform_memory #(.MEM_AW(MEM_AW)) u_waveform_memory (
		.word_clock        (word_clock),
		.reset4_word_clock (reset4_word_clock),
		.frame             (frame_ce1),
		.transaction_valid (transaction_valid_ce1),
		.read_word         (read_word_ce1),
		.sample_address    (sample_address),
		.sample_out        (sample_out)
	);

	playback_sequencer #(.MEM_AW(MEM_AW)) u_playback_sequencer (
		.word_clock        (word_clock),
		.reset4_word_clock (reset4_word_clock),
		.start_reg         (start_reg),
		.end_reg           (end_reg),
		.sample_address    (sample_address),
		.sync_out          (sync_out)
	);

	assign spi_miso = spi_ce0_n ? miso_ce1 : miso_ce0; // selected slave drives

	// high from the clock after reset drops
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			ready <= 1'b0;
		end else begin
			ready <= 1'b1;
		end
	end

endmodule

// ==== design/control_registers.sv ====
`timescale 1ns/10ps
/*
 bank of 32-bit control registers written and read over SPI,
 playback window start and end exported to the sequencer
*/
module control_registers import awg_pkg::*; #(
	parameter int REG_AW = 4
) (
	input  logic        word_clock,
	input  logic        reset4_word_clock,
	input  spi_frame_t  frame,
	input  logic        transaction_valid,
	output logic [31:0] read_word,
	output logic [31:0] start_reg,
	output logic [31:0] end_reg
);
	localparam int NUM_REGS = 1 << REG_AW;
	localparam logic [31:0] DEFAULT_END = 32'd16; // 4-byte loop out of reset

	logic [31:0] regs [NUM_REGS];
	logic [REG_AW-1:0] reg_index;
	logic write_en;

	assign reg_index = frame.address16[REG_AW-1:0]; // upper address bits ignored
	assign write_en = transaction_valid && frame.command8 == CMD_WRITE;

	// ------------------------------
	// register writes
	// ------------------------------
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
			regs[REG_END] <= DEFAULT_END;
		end else if (write_en) begin
			regs[reg_index] <= frame.data32;
		end
	end

	// ------------------------------
	// readback
	// ------------------------------

	// follows the address as it arrives, ready one clock later
	always_ff @(posedge word_clock) begin
		read_word <= regs[reg_index];
	end

	// window taps
	assign start_reg = regs[REG_START];
	assign end_reg = regs[REG_END];

endmodule

// ==== design/playback_sequencer.sv ====
`timescale 1ns/10ps
/*
 looping playback byte address generator with window reload at each wrap,
 sync pulse aligned to the first sample of every pass
*/
module playback_sequencer import awg_pkg::*; #(
	parameter int MEM_AW = 12
) (
	input  logic              word_clock,
	input  logic              reset4_word_clock,
	input  logic [31:0]       start_reg,
	input  logic [31:0]       end_reg,
	output logic [MEM_AW+1:0] sample_address,
	output logic              sync_out
);
	localparam int BW = MEM_AW + 2; // byte address width

	logic [SAMPLE_AW-1:0] start_sample;
	logic [SAMPLE_AW-1:0] end_sample;
	logic [BW-1:0] start_byte;
	logic [BW-1:0] end_byte;
	logic [BW-1:0] first_address; // window of the current pass
	logic [BW-1:0] last_address;
	logic reload;
	logic sync_raw;

	assign start_sample = start_reg[SAMPLE_AW+1:2];
	assign end_sample = end_reg[SAMPLE_AW+1:2];
	assign start_byte = BW'(start_sample);
	assign end_byte = BW'(end_sample);

	// ------------------------------
	// address counter
	// ------------------------------
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			sample_address <= '0;
			first_address <= '0;
			last_address <= '0;
			reload <= 1'b1; // first clock out of reset starts a pass
			sync_raw <= 1'b0;
		end else if (reload || sample_address == last_address) begin
			sample_address <= start_byte;
			first_address <= start_byte;
			last_address <= end_byte - 1'b1; // window change lands here
			reload <= 1'b0;
			sync_raw <= 1'b1;
		end else begin
			sample_address <= sample_address + 1'b1;
			sync_raw <= 1'b0;
		end
	end

	// memory read adds a clock, keep sync on the start byte
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			sync_out <= 1'b0;
		end else begin
			sync_out <= sync_raw;
		end
	end

	assert property (@(posedge word_clock) disable iff (reset4_word_clock)
		!reload |-> (sample_address >= first_address && sample_address <= last_address))
		else $error("playback address outside the window");

endmodule

// ==== design/spi_slave_cmd_addr_data.sv ====
`timescale 1ns/10ps
/*
 SPI mode 0 slave for 8-bit command, 16-bit address and 32-bit data frames,
 oversampled on word_clock; returns read_word on MISO during the data phase
*/
module spi_slave_cmd_addr_data import awg_pkg::*; (
	input  logic        word_clock,
	input  logic        reset4_word_clock,
	input  logic        sclk,
	input  logic        mosi,
	input  logic        ssel_n,
	output logic        miso,
	output spi_frame_t  frame,
	output logic        transaction_valid,
	input  logic [31:0] read_word
);
	localparam int CMD_BITS = 8;
	localparam int ADDR_END = 24; // command plus address
	localparam int FRAME_BITS = 56;

	// ------------------------------
	// pin synchronizers
	// ------------------------------
	logic [1:0] sclk_sync;
	logic [1:0] mosi_sync;
	logic [1:0] ssel_sync;
	logic sclk_last;
	logic ssel_last;
	logic selected;
	logic sclk_rise;
	logic sclk_fall;
	logic ssel_fall;
	logic ssel_rise;

	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			sclk_sync <= 2'b00;
			ssel_sync <= 2'b11; // idle deselected
			sclk_last <= 1'b0;
			ssel_last <= 1'b1;
		end else begin
			sclk_sync <= {sclk_sync[0], sclk};
			ssel_sync <= {ssel_sync[0], ssel_n};
			sclk_last <= sclk_sync[1];
			ssel_last <= ssel_sync[1];
		end
	end

	// data pin, same latency as sclk
	always_ff @(posedge word_clock) begin
		mosi_sync <= {mosi_sync[0], mosi};
	end

	assign selected = ~ssel_sync[1];
	assign sclk_rise = selected & sclk_sync[1] & ~sclk_last;
	assign sclk_fall = selected & ~sclk_sync[1] & sclk_last;
	assign ssel_fall = ~ssel_sync[1] & ssel_last; // start of frame
	assign ssel_rise = ssel_sync[1] & ~ssel_last;  // end of frame

	// ------------------------------
	// receive side
	// ------------------------------
	logic [5:0] bit_count;

	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			bit_count <= '0;
		end else if (ssel_fall) begin
			bit_count <= '0;
		end else if (sclk_rise && bit_count != 6'h3f) begin
			bit_count <= bit_count + 6'd1; // saturates so long frames never alias to 56
		end
	end

	// fields fill in wire order, address is complete right after bit 24
	always_ff @(posedge word_clock) begin
		if (sclk_rise) begin
			if (bit_count < 6'(CMD_BITS)) begin
				frame.command8 <= {frame.command8[6:0], mosi_sync[1]};
			end else if (bit_count < 6'(ADDR_END)) begin
				frame.address16 <= {frame.address16[14:0], mosi_sync[1]};
			end else begin
				frame.data32 <= {frame.data32[30:0], mosi_sync[1]};
			end
		end
	end

	// ------------------------------
	// transmit side
	// ------------------------------
	logic [31:0] miso_shift;

	// first falling edge after bit 24 puts the msb of read_word out
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock || ssel_rise) begin
			miso_shift <= '0;
		end else if (sclk_fall) begin
			if (bit_count == 6'(ADDR_END)) begin
				miso_shift <= read_word;
			end else begin
				miso_shift <= {miso_shift[30:0], 1'b0};
			end
		end
	end

	assign miso = miso_shift[31];

	// one pulse per complete frame, 3 clocks after ssel_n goes high
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			transaction_valid <= 1'b0;
		end else begin
			transaction_valid <= ssel_rise && bit_count == 6'(FRAME_BITS);
		end
	end

	assert property (@(posedge word_clock) disable iff (reset4_word_clock)
		transaction_valid |=> !transaction_valid)
		else $error("transaction_valid held for more than one cycle");

endmodule

// ==== design/waveform_memory.sv ====
`timescale 1ns/10ps
/*
 waveform memory with a 32-bit SPI read/write port
 and an 8-bit registered playback read port
*/
module waveform_memory import awg_pkg::*; #(
	parameter int MEM_AW = 12
) (
	input  logic              word_clock,
	input  logic              reset4_word_clock,
	input  spi_frame_t        frame,
	input  logic              transaction_valid,
	output logic [31:0]       read_word,
	input  logic [MEM_AW+1:0] sample_address,
	output logic [7:0]        sample_out
);
	localparam int DEPTH = 1 << MEM_AW;

	sample_word_u mem [DEPTH];
	logic [MEM_AW-1:0] word_index;
	logic write_en;
	sample_word_u spi_in;     // word as received
	sample_word_u readback_q; // word as stored
	sample_word_u spi_out;

	// reverse byte order between spi and storage
	function automatic sample_word_u byte_swap(input sample_word_u w);
		sample_word_u swapped;
		for (int i = 0; i < 4; i++) begin
			swapped.bytes[i] = w.bytes[3-i];
		end
		return swapped;
	endfunction

	assign word_index = frame.address16[MEM_AW-1:0];
	assign write_en = transaction_valid && frame.command8 == CMD_WRITE;
	assign spi_in.word32 = frame.data32;

	// ------------------------------
	// spi port
	// ------------------------------
	always_ff @(posedge word_clock) begin
		if (write_en) begin
			mem[word_index] <= byte_swap(spi_in);
		end
		readback_q <= mem[word_index];
	end

	assign spi_out = byte_swap(readback_q);
	assign read_word = spi_out.word32;

	// ------------------------------
	// playback port
	// ------------------------------
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			sample_out <= '0;
		end else begin
			sample_out <= mem[sample_address[MEM_AW+1:2]].bytes[sample_address[1:0]];
		end
	end

	assert property (@(posedge word_clock) disable iff (reset4_word_clock)
		write_en |-> !$isunknown(word_index))
		else $error("memory write with unknown address");

endmodule

// ==== sim.f ====
design/awg_pkg.sv
design/spi_slave_cmd_addr_data.sv
design/control_registers.sv
design/waveform_memory.sv
design/playback_sequencer.sv
design/awg_top.sv
test/clock_gen.sv
test/tb_awg.sv

// ==== test/awg_tests.txt ====
# one operation per line, all numbers hex; cs 0 is registers, cs 1 is memory
# write cs addr data | read cs addr expected | verify cs addr | fill word count
# window start_byte end_byte passes | end
# control register write and readback
write 0 0002 a5a51234
read 0 0002 a5a51234
write 0 0005 0badf00d
write 0 000f ffffffff
read 0 0005 0badf00d
read 0 000f ffffffff
read 0 0003 00000000
read 0 0001 00000010
read 0 0000 00000000
# memory words, the second read follows a read-only command
write 1 0000 00112233
read 1 0000 00112233
read 1 0000 00112233
write 1 0001 44556677
write 1 0002 8899aabb
write 1 0003 ccddeeff
read 1 0002 8899aabb
fill 0004 000c
fill 0020 0008
verify 1 0007
verify 1 000f
verify 1 0023
# playback windows, each change checked from the next wrap on
window 0000 0010 3
window 0004 000e 3
window 0009 000a 4
window 0081 009b 2
window 0010 0040 2
window 0003 0021 2
# other registers untouched by the window writes
verify 0 0002
verify 0 0005
verify 0 000f
verify 0 0000
verify 0 0001
end

// ==== test/clock_gen.sv ====
`timescale 1ns/10ps
/* testbench clock, 10 ns period, and reset held for the first cycles */
module clock_gen #(
	parameter int RESET_CYCLES = 5
) (
	output logic word_clock,
	output logic reset4_word_clock
);
	initial begin
		word_clock = 1'b0;
		forever #5 word_clock = ~word_clock;
	end

	initial begin
		reset4_word_clock = 1'b1;
		repeat (RESET_CYCLES) @(posedge word_clock);
		@(negedge word_clock);
		reset4_word_clock <= 1'b0; // released on a falling edge
	end
endmodule

// ==== test/tb_awg.sv ====
`timescale 1ns/10ps
/*
 testbench for the waveform player: SPI master, file-driven operations,
 register and memory readback, playback pass length and content checks
*/
module tb_awg import awg_pkg::*; ();
	localparam int SPI_HALF = 8;          // word_clock cycles per sck half period
	localparam int SETTLE = 10;           // clocks after deselect until the write has landed
	localparam int SYNC_TIMEOUT = 20000;
	localparam int RESET_TIMEOUT = 50;
	localparam logic [7:0] CMD_READ = 8'h02;
	localparam TEST_FILE = "test/awg_tests.txt";

	logic word_clock;
	logic reset4_word_clock;
	logic spi_sclk;
	logic spi_mosi;
	logic spi_ce0_n;
	logic spi_ce1_n;
	logic spi_miso;
	logic [7:0] sample_out;
	logic sync_out;
	logic ready;

	logic [31:0] reg_model [16];   // every write the testbench has made
	logic [31:0] mem_model [4096];
	int cur_end;                   // end byte of the window now programmed
	integer seed;

	clock_gen u_clock_gen (.word_clock(word_clock), .reset4_word_clock(reset4_word_clock));

	awg_top #(.MEM_AW(12), .REG_AW(4)) u_awg_top (
		.word_clock        (word_clock),
		.reset4_word_clock (reset4_word_clock),
		.spi_sclk          (spi_sclk),
		.spi_mosi          (spi_mosi),
		.spi_ce0_n         (spi_ce0_n),
		.spi_ce1_n         (spi_ce1_n),
		.spi_miso          (spi_miso),
		.sample_out        (sample_out),
		.sync_out          (sync_out),
		.ready             (ready)
	);

	// ------------------------------
	// failure reporting
	// ------------------------------
	task automatic stop_on_failure();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic value_error(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		stop_on_failure();
	endtask

	task automatic timeout_failure(input string what);
		$display("timeout: %s never happened", what);
		stop_on_failure();
	endtask

	// ------------------------------
	// spi master, mode 0
	// ------------------------------
	task automatic hold_cycles(input int n);
		repeat (n) @(negedge word_clock);
	endtask

	task automatic spi_transfer(input int cs, input logic [7:0] cmd, input logic [15:0] addr,
		input logic [31:0] data, output logic [31:0] miso_word);
		logic [55:0] bits;
		bits = {cmd, addr, data};
		miso_word = '0;
		@(negedge word_clock);
		if (cs == 0) spi_ce0_n = 1'b0;
		else spi_ce1_n = 1'b0;
		hold_cycles(SPI_HALF);
		for (int i = 55; i >= 0; i--) begin
			spi_mosi = bits[i];
			hold_cycles(SPI_HALF);
			if (i < 32) miso_word = {miso_word[30:0], spi_miso}; // sampled at the rising edge
			spi_sclk = 1'b1;
			hold_cycles(SPI_HALF);
			spi_sclk = 1'b0;
		end
		hold_cycles(SPI_HALF);
		spi_ce0_n = 1'b1;
		spi_ce1_n = 1'b1;
		hold_cycles(SETTLE);
	endtask

	task automatic write_word(input int cs, input logic [15:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		spi_transfer(cs, CMD_WRITE, addr, data, unused);
		if (cs == 0) reg_model[addr[3:0]] = data;
		else mem_model[addr[11:0]] = data;
	endtask

	// read frame carries the inverted word, so a stray write would show up later
	task automatic read_and_compare(input int cs, input logic [15:0] addr,
		input logic [31:0] expected);
		logic [31:0] got;
		spi_transfer(cs, CMD_READ, addr, ~expected, got);
		assert (got === expected)
			else value_error($sformatf("cs%0d addr %h read %h, expected %h", cs, addr, got,
				expected));
	endtask

	task automatic fill_random(input int first_word, input int count);
		for (int i = 0; i < count; i++) begin
			write_word(1, first_word + i, $random(seed));
		end
	endtask

	// ------------------------------
	// playback
	// ------------------------------
	function automatic logic [7:0] expected_byte(input int b);
		logic [31:0] w;
		w = mem_model[b / 4];
		return w[8 * (3 - b % 4) +: 8]; // msb of the word plays first
	endfunction

	// order the two writes so that a wrap in between never sees start past end
	task automatic program_window(input int new_start, input int new_end);
		if (new_start < cur_end) begin
			write_word(0, REG_START, new_start << 2);
			write_word(0, REG_END, new_end << 2);
		end else begin
			write_word(0, REG_END, new_end << 2);
			write_word(0, REG_START, new_start << 2);
		end
		cur_end = new_end;
	endtask

	task automatic wait_for_sync();
		int cycles;
		cycles = 0;
		while (!sync_out) begin
			@(negedge word_clock);
			cycles++;
			if (cycles > SYNC_TIMEOUT) timeout_failure("a sync_out pulse");
		end
	endtask

	task automatic check_passes(input int first_byte, input int end_byte, input int passes);
		int length;
		int index;
		logic pass_done;
		length = end_byte - first_byte;
		wait_for_sync();
		for (int p = 0; p < passes; p++) begin
			index = 0;
			pass_done = 1'b0;
			while (!pass_done) begin
				assert (index < length)
					else value_error($sformatf("pass %0d longer than %0d bytes", p, length));
				assert (sample_out === expected_byte(first_byte + index))
					else value_error($sformatf("byte %h played %h, expected %h",
						first_byte + index, sample_out, expected_byte(first_byte + index)));
				index++;
				@(negedge word_clock);
				pass_done = sync_out;
			end
			assert (index == length)
				else value_error($sformatf("pass %0d was %0d bytes, expected %0d", p, index,
					length));
		end
	endtask

	task automatic require_operands(input int got, input int want);
		if (got != want) begin
			$display("malformed line in the test file, %0d operands where %0d belong", got, want);
			stop_on_failure();
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		logic [8*16-1:0] op;
		logic [8*160-1:0] line;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		int fd;
		int n;
		int cycles;
		logic done;
		spi_sclk = 1'b0;
		spi_mosi = 1'b0;
		spi_ce0_n = 1'b1;
		spi_ce1_n = 1'b1;
		seed = 32'hcc501652;
		for (int i = 0; i < 16; i++) reg_model[i] = '0;
		reg_model[REG_END] = 32'd16; // reset window is bytes 0 to 3
		cur_end = 4;

		@(negedge word_clock);
		cycles = 0;
		while (reset4_word_clock) begin
			assert (ready === 1'b0 && sync_out === 1'b0 && sample_out === 8'h00)
				else value_error("outputs not idle during reset");
			@(negedge word_clock);
			cycles++;
			if (cycles > RESET_TIMEOUT) timeout_failure("release of reset4_word_clock");
		end
		assert (ready === 1'b1) else value_error("ready not high one clock after reset release");

		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			$display("could not open the test file %s", TEST_FILE);
			stop_on_failure();
		end
		done = 1'b0;
		while (!done) begin
			if ($fscanf(fd, "%s", op) != 1) begin
				done = 1'b1;
			end else if (op == "#") begin
				n = $fgets(line, fd);
			end else if (op == "write") begin
				n = $fscanf(fd, "%h %h %h", f1, f2, f3);
				require_operands(n, 3);
				write_word(f1, f2, f3);
			end else if (op == "read") begin
				n = $fscanf(fd, "%h %h %h", f1, f2, f3);
				require_operands(n, 3);
				read_and_compare(f1, f2, f3);
			end else if (op == "verify") begin
				n = $fscanf(fd, "%h %h", f1, f2);
				require_operands(n, 2);
				read_and_compare(f1, f2, (f1 == 0) ? reg_model[f2[3:0]] : mem_model[f2[11:0]]);
			end else if (op == "fill") begin
				n = $fscanf(fd, "%h %h", f1, f2);
				require_operands(n, 2);
				fill_random(f1, f2);
			end else if (op == "window") begin
				n = $fscanf(fd, "%h %h %h", f1, f2, f3);
				require_operands(n, 3);
				program_window(f1, f2);
				check_passes(f1, f2, f3);
			end else if (op == "end") begin
				done = 1'b1;
			end else begin
				$display("unknown operation %0s in the test file", op);
				stop_on_failure();
			end
		end
		$fclose(fd);

		$display("RESULT: PASS");
		$finish;
	end
endmodule
